// File: bench/vic_tb.sv
// vic testbench
`timescale 1ns/1ps
`include "vic_cfg.svh"

module vic_tb;
    import vic_pkg::*;

    localparam int LINE_TICKS = `VIC_CYCLES_PER_LINE * `VIC_PHASES_PER_CYCLE;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_WAIT} op_t;

    typedef struct packed {
        op_t         op;
        logic [5:0]  addr;
        logic [15:0] data;  // write data, or line starts to wait for
        logic [7:0]  exp;   // read value, or irq level after a wait
    } step_t;

    logic       clk_col16x_ntsc;
    logic       reset;
    logic       ce;
    logic       rw;
    logic [5:0] adl_in;
    logic [7:0] dbl_in;
    logic [3:0] dbh;
    logic [5:0] adl_out;
    logic [5:0] adl_oe;
    logic [5:0] adh;
    logic [7:0] dbl_out;
    logic [7:0] dbl_oe;
    logic       clk_phi;
    logic       aec;
    logic       irq;
    logic       cpu_reset;

    step_t      steps [$];
    integer     seed = 32'h1685_23f5;
    integer     ticks = 0;          // clocks since reset release
    integer     phi_rises = 0;      // clk_phi rising edges seen since reset
    integer     run_len = 0;
    logic       phi_prev = 1'b0;
    logic       phi_exp = 1'b0;     // expected clk_phi from the tick count
    logic       runs_valid = 1'b0;  // first low run after reset is short
    logic [3:0] vb_model = 4'h0;    // expected video base nibble
    logic       table_ready = 1'b0;
    integer     limit = 0;
    integer     error_count = 0;
    integer     check_count = 0;

    vic_top uut (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .reset           (reset),
        .ce              (ce),
        .rw              (rw),
        .adl_in          (adl_in),
        .dbl_in          (dbl_in),
        .dbh             (dbh),
        .adl_out         (adl_out),
        .adl_oe          (adl_oe),
        .adh             (adh),
        .dbl_out         (dbl_out),
        .dbl_oe          (dbl_oe),
        .clk_phi         (clk_phi),
        .aec             (aec),
        .irq             (irq),
        .cpu_reset       (cpu_reset)
    );

    initial
    begin
        clk_col16x_ntsc = 1'b0;
        forever #50 clk_col16x_ntsc = ~clk_col16x_ntsc;   // 100 ns period
    end

    always @(posedge clk_col16x_ntsc)
    begin
        if (reset)
            ticks <= 0;
        else
            ticks <= ticks + 1;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count = check_count + 1;
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED: %s got %0h expected %0h at %0t", name, got, exp, $time);
            error_count = error_count + 1;
        end
    endtask

    task automatic add_step(input op_t op, input logic [5:0] addr, input logic [15:0] data,
                            input logic [7:0] exp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endtask

    // random write, then a read that expects only the implemented bits
    task automatic add_write_readback(input logic [5:0] addr, input logic [7:0] mask);
        logic [7:0] v;
        v = 8'($random(seed));
        add_step(OP_WRITE, addr, {8'h00, v}, 8'h00);
        add_step(OP_READ, addr, 16'h0000, v & mask);
    endtask

    // one cpu access in the phi high half with the check in phase 14
    task automatic bus_access(input logic write, input logic [5:0] addr,
                              input logic [7:0] wdata, input logic [7:0] exp);
        @(posedge clk_phi);
        @(negedge clk_col16x_ntsc);
        ce     = 1'b0;
        rw     = ~write;
        adl_in = addr;
        dbl_in = wdata;
        repeat (6) @(negedge clk_col16x_ntsc);  // sampled at 12 with data out from 14
        if (write)
            check_value("dbl_oe", 32'(dbl_oe), 32'h00);
        else
        begin
            check_value("dbl_oe", 32'(dbl_oe), 32'hFF);
            check_value("dbl_out", 32'(dbl_out), 32'(exp));
        end
        ce     = 1'b1;
        rw     = 1'b1;
        adl_in = 6'h00;
        dbl_in = 8'h00;
        if (write && addr == REG_VIDEO_BASE)
            vb_model = wdata[7:4];
    endtask

    // irq settles two clocks into a line so the check sits one bus cycle in
    task automatic wait_for_lines(input int lines, input logic exp_irq);
        int target;
        target = ticks / LINE_TICKS + lines;
        while (ticks / LINE_TICKS < target)
            @(negedge clk_col16x_ntsc);
        repeat (`VIC_PHASES_PER_CYCLE) @(negedge clk_col16x_ntsc);
        check_value("irq", 32'(irq), 32'(exp_irq));
    endtask

    // free running checks of phase timing, bus enables and fetch address
    always @(negedge clk_col16x_ntsc)
    begin
        if (reset)
        begin
            phi_prev   = 1'b0;
            run_len    = 0;
            runs_valid = 1'b0;
            phi_rises  = 0;
        end
        else if (ticks > 0)
        begin
            phi_exp = ((ticks % `VIC_PHASES_PER_CYCLE) >= `VIC_PHI_HIGH_START);
            if (clk_phi && !phi_prev)
                phi_rises = phi_rises + 1;
            if (clk_phi == phi_prev)
                run_len = run_len + 1;
            else
            begin
                if (runs_valid)
                    check_value("clk_phi run length", run_len, phi_prev ?
                        `VIC_PHASES_PER_CYCLE - `VIC_PHI_HIGH_START : `VIC_PHI_HIGH_START);
                runs_valid = 1'b1;
                run_len    = 1;
            end
            phi_prev = clk_phi;
            check_value("clk_phi", 32'(clk_phi), 32'(phi_exp));
            check_value("aec", 32'(aec), 32'(!phi_exp));
            check_value("adl_oe", 32'(adl_oe), phi_exp ? 32'h00 : 32'h3F);
            check_value("cpu_reset", 32'(cpu_reset), (ticks < LINE_TICKS) ? 32'h1 : 32'h0);
            if (!phi_exp)
            begin
                check_value("dbl_oe", 32'(dbl_oe), 32'h00);   // vic owns the bus
                check_value("adh,adl_out", 32'({adh, adl_out}),
                    32'({vb_model, 8'(phi_rises % `VIC_CYCLES_PER_LINE)}));
            end
        end
    end

    initial
    begin
        wait (table_ready);
        repeat (limit) @(posedge clk_col16x_ntsc);
        $display("watchdog expired after %0d clocks before the table finished", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        int i;
        int wait_total;
        reset  = 1'b1;
        ce     = 1'b1;
        rw     = 1'b1;
        adl_in = 6'h00;
        dbl_in = 8'h00;
        dbh    = 4'h0;

        add_write_readback(REG_VIDEO_BASE, 8'hF0);
        add_write_readback(REG_BORDER, 8'h0F);
        add_write_readback(REG_IRQ_ENABLE, 8'h0F);
        add_step(OP_READ, 6'h3F, 16'h0000, 8'hFF);           // open slot
        add_step(OP_READ, REG_RASTER, 16'h0000, 8'h00);      // still line 0
        add_step(OP_READ, REG_CONTROL1, 16'h0000, 8'h00);
        add_step(OP_WRITE, REG_IRQ_ENABLE, 16'h0000, 8'h00);
        add_step(OP_WRITE, REG_RASTER, 16'h0002, 8'h00);     // compare on line 2
        add_step(OP_WRITE, REG_CONTROL1, 16'h0000, 8'h00);
        add_step(OP_WRITE, REG_IRQ_STATUS, 16'h0001, 8'h00); // drop the line 0 match
        add_step(OP_READ, REG_IRQ_STATUS, 16'h0000, 8'h00);
        add_step(OP_WRITE, REG_IRQ_ENABLE, 16'h0001, 8'h00);
        add_step(OP_READ, REG_IRQ_STATUS, 16'h0000, 8'h00);
        add_step(OP_WAIT, 6'h00, 16'd1, 8'h01);              // line 1 without a match
        add_step(OP_READ, REG_RASTER, 16'h0000, 8'h01);      // live counter, not the compare
        add_step(OP_WAIT, 6'h00, 16'd1, 8'h00);              // line 2 fires
        add_step(OP_READ, REG_IRQ_STATUS, 16'h0000, 8'h81);
        add_step(OP_WRITE, REG_IRQ_STATUS, 16'h0001, 8'h00); // ack
        add_step(OP_WAIT, 6'h00, 16'd0, 8'h01);
        add_step(OP_READ, REG_IRQ_STATUS, 16'h0000, 8'h00);
        add_step(OP_WRITE, REG_IRQ_ENABLE, 16'h0000, 8'h00);
        add_step(OP_WAIT, 6'h00, 16'(`VIC_LINES), 8'h01);     // line 2 of the next frame
        add_step(OP_READ, REG_IRQ_STATUS, 16'h0000, 8'h01);  // latched but masked
        add_step(OP_READ, REG_RASTER, 16'h0000, 8'h02);
        add_step(OP_READ, REG_CONTROL1, 16'h0000, 8'h00);

        wait_total = 0;
        for (i = 0; i < steps.size(); i++)
        begin
            if (steps[i].op == OP_WAIT)
                wait_total = wait_total + int'(steps[i].data);
        end
        limit = (wait_total + 2) * LINE_TICKS + steps.size() * 2 * `VIC_PHASES_PER_CYCLE;
        table_ready = 1'b1;

        repeat (4) @(negedge clk_col16x_ntsc);
        reset = 1'b0;
        check_value("irq", 32'(irq), 32'h1);
        check_value("dbl_oe", 32'(dbl_oe), 32'h00);
        check_value("adl_oe", 32'(adl_oe), 32'h00);
        check_value("clk_phi", 32'(clk_phi), 32'h0);
        check_value("cpu_reset", 32'(cpu_reset), 32'h1);

        for (i = 0; i < steps.size(); i++)
        begin
            case (steps[i].op)
                OP_WRITE: bus_access(1'b1, steps[i].addr, steps[i].data[7:0], 8'h00);
                OP_READ:  bus_access(1'b0, steps[i].addr, 8'h00, steps[i].exp);
                default:  wait_for_lines(int'(steps[i].data), steps[i].exp[0]);
            endcase
        end

        $display("checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/vic_pkg.sv
hw/vic_bus_if.sv
hw/cycle_timer.sv
hw/cpu_bus_port.sv
hw/vic_regs.sv
hw/fetch_addr_gen.sv
hw/vic_top.sv
bench/vic_tb.sv

// File: hw/cpu_bus_port.sv
// cpu bus port
`timescale 1ns/1ps
`include "vic_cfg.svh"

module cpu_bus_port (
    input  logic       clk_col16x_ntsc,
    input  logic       reset,
    input  logic [3:0] phase,
    input  logic       ce,      // low selects the chip
    input  logic       rw,      // high read, low write
    input  logic [5:0] adl_in,
    input  logic [7:0] dbl_in,
    vic_bus_if.ctrl    bus,
    output logic [7:0] dbl_out,
    output logic [7:0] dbl_oe
);
    import vic_pkg::*;

    logic sample;   // access is captured on this edge
    logic last;     // final tick of the cpu half

    assign sample = (phase == 4'(`VIC_SAMPLE_PHASE)) && !ce;
    assign last   = (phase == 4'(`VIC_PHASES_PER_CYCLE - 1));

    // control strobes
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (reset)
        begin
            bus.we <= 1'b0;
            bus.re <= 1'b0;
            dbl_oe <= 8'h00;
        end
        else
        begin
            bus.we <= 1'b0;     // write strobe lasts one clock
            if (sample)
            begin
                bus.we <= !rw;
                bus.re <= rw;   // read window opens on phase 13
                dbl_oe <= rw ? 8'hFF : 8'h00;
            end
            else if (last)
            begin
                // window closes as phi falls
                bus.re <= 1'b0;
                dbl_oe <= 8'h00;
            end
        end
    end

    // address and data payload
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (sample)
        begin
            bus.addr  <= reg_addr_t'(adl_in);
            bus.wdata <= dbl_in;
        end
        if (bus.re)
            dbl_out <= bus.rdata;   // valid from phase 14
    end

endmodule

// File: hw/cycle_timer.sv
// bus cycle and raster timer
`timescale 1ns/1ps
`include "vic_cfg.svh"

module cycle_timer (
    input  logic                     clk_col16x_ntsc,
    input  logic                     reset,
    output logic [3:0]               phase,
    output vic_pkg::bus_phase_t      bus_phase,
    output logic                     clk_phi,
    output logic                     cycle_end,
    output logic [7:0]               hcycle,
    output logic [`VIC_RASTER_W-1:0] raster,
    output logic                     cpu_reset
);
    import vic_pkg::*;

    logic [3:0] phase_next;
    logic       line_end;   // last tick of the last cycle on a line

    always_comb
    begin
        if (phase == 4'(`VIC_PHASES_PER_CYCLE - 1))
            phase_next = 4'd0;
        else
            phase_next = phase + 4'd1;
    end

    assign cycle_end = (phase == 4'(`VIC_PHASES_PER_CYCLE - 1));
    assign line_end  = cycle_end && (hcycle == 8'(`VIC_CYCLES_PER_LINE - 1));

    // bus_phase looks one tick ahead so that registered enables line up with clk_phi
    assign bus_phase = (phase_next >= 4'(`VIC_PHI_HIGH_START)) ? PHASE_CPU : PHASE_VIC;

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (reset)
        begin
            phase     <= 4'd0;
            clk_phi   <= 1'b0;
            hcycle    <= 8'd0;
            raster    <= '0;
            cpu_reset <= 1'b1;  // hold the 6510 in reset
        end
        else
        begin
            phase   <= phase_next;
            clk_phi <= (bus_phase == PHASE_CPU);   // high for phases 8..15
            if (cycle_end)
                hcycle <= line_end ? 8'd0 : hcycle + 8'd1;
            if (line_end)
            begin
                if (raster == `VIC_RASTER_W'(`VIC_LINES - 1))
                    raster <= '0;   // frame wrap
                else
                    raster <= raster + 1'b1;
                cpu_reset <= 1'b0;  // one full line has passed
            end
        end
    end

endmodule

// File: hw/fetch_addr_gen.sv
// vic fetch address generator
`timescale 1ns/1ps
`include "vic_cfg.svh"

module fetch_addr_gen (
    input  logic                   clk_col16x_ntsc,
    input  logic                   reset,
    input  vic_pkg::bus_phase_t    bus_phase,   // half of the next tick
    input  logic [7:0]             hcycle,
    input  logic [3:0]             video_base,
    output logic [`VIC_ADDR_W-1:0] fetch_addr,
    output logic                   addr_drive
);
    import vic_pkg::*;

    logic       started;        // first cpu half seen since reset
    logic [7:0] hcycle_next;    // hcycle after the coming cycle edge

    // on the phase 15 edge hcycle moves too, so load the value it is about to take
    always_comb
    begin
        if (hcycle == 8'(`VIC_CYCLES_PER_LINE - 1))
            hcycle_next = 8'd0;
        else
            hcycle_next = hcycle + 8'd1;
    end

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (reset)
        begin
            addr_drive <= 1'b0;
            started    <= 1'b0;
        end
        else
        begin
            addr_drive <= (bus_phase == PHASE_VIC);  // high for phases 0..7
            if (bus_phase == PHASE_CPU)
                started <= 1'b1;
        end
    end

    // video base nibble on top, cycle count below
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (bus_phase == PHASE_VIC)
            fetch_addr <= {video_base, (addr_drive || !started) ? hcycle : hcycle_next};
    end

endmodule

// File: hw/vic_bus_if.sv
// register access bus
`timescale 1ns/1ps

interface vic_bus_if;
    import vic_pkg::*;

    reg_addr_t  addr;   // register slot, held through the access
    logic [7:0] wdata;  // write data
    logic       we;     // one clock strobe
    logic       re;     // high for the whole read window
    logic [7:0] rdata;  // combinational from addr

    // bus port side
    modport ctrl (
        output addr,
        output wdata,
        output we,
        output re,
        input  rdata
    );

    // register file side
    modport regs (
        input  addr,
        input  wdata,
        input  we,
        input  re,
        output rdata
    );

endinterface

// File: hw/vic_cfg.svh
// vic timing and bus geometry
`ifndef VIC_CFG_SVH
`define VIC_CFG_SVH

// one bus cycle is sixteen color clocks
`define VIC_PHASES_PER_CYCLE 16
`define VIC_PHI_HIGH_START   8    // phi rises here, cpu half follows
`define VIC_SAMPLE_PHASE     12   // cpu access captured on this phase

// ntsc 6567r8 raster geometry
`define VIC_CYCLES_PER_LINE  65
`define VIC_LINES            263
`define VIC_RASTER_W         9

// bus widths
`define VIC_ADDR_W           12   // 6 low + 6 high address pins
`define VIC_REG_ADDR_W       6    // cpu sees 64 register slots

`endif

// File: hw/vic_pkg.sv
// vic shared types
`include "vic_cfg.svh"

package vic_pkg;

    // cpu visible register map, a subset of the 6567 layout
    typedef enum logic [`VIC_REG_ADDR_W-1:0] {
        REG_CONTROL1   = 6'h11, // bit 7 is raster bit 8
        REG_RASTER     = 6'h12, // raster low byte
        REG_VIDEO_BASE = 6'h18, // upper nibble only
        REG_IRQ_STATUS = 6'h19, // write 1 to clear
        REG_IRQ_ENABLE = 6'h1A,
        REG_BORDER     = 6'h20  // low nibble only
    } reg_addr_t;

    // which side owns the bus
    // PHASE_VIC while phi is low, PHASE_CPU while phi is high
    typedef enum logic {
        PHASE_VIC = 1'b0,
        PHASE_CPU = 1'b1
    } bus_phase_t;

endpackage

// File: hw/vic_regs.sv
// vic register file and raster irq
`timescale 1ns/1ps
`include "vic_cfg.svh"

module vic_regs (
    input  logic                     clk_col16x_ntsc,
    input  logic                     reset,
    input  logic [7:0]               hcycle,
    input  logic [`VIC_RASTER_W-1:0] raster,
    input  logic [3:0]               phase,
    vic_bus_if.regs                  bus,
    output logic [3:0]               video_base,
    output logic                     irq        // active low
);
    import vic_pkg::*;

    logic [`VIC_RASTER_W-1:0] compare;      // raster irq line
    logic [3:0]               irq_en;
    logic [3:0]               irq_status;   // bit 0 raster, rest unused here
    logic [3:0]               border;
    logic [3:0]               pending;      // enabled and latched
    logic                     raster_hit;

    assign pending = irq_status & irq_en;

    // only checked once per line, on the first tick of cycle 0
    assign raster_hit = (hcycle == 8'd0) && (phase == 4'd0) && (raster == compare);

    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (reset)
        begin
            compare    <= '0;
            irq_en     <= 4'h0;
            irq_status <= 4'h0;
            video_base <= 4'h0;
            border     <= 4'h0;
            irq        <= 1'b1;
        end
        else
        begin
            if (bus.we)
            begin
                case (bus.addr)
                    REG_CONTROL1:   compare[`VIC_RASTER_W-1] <= bus.wdata[7];
                    REG_RASTER:     compare[7:0] <= bus.wdata;
                    REG_VIDEO_BASE: video_base <= bus.wdata[7:4];
                    REG_IRQ_STATUS: irq_status <= irq_status & ~bus.wdata[3:0]; // ack
                    REG_IRQ_ENABLE: irq_en <= bus.wdata[3:0];
                    REG_BORDER:     border <= bus.wdata[3:0];
                    default:        ;
                endcase
            end
            if (raster_hit)
                irq_status[0] <= 1'b1;
            irq <= ~|pending;   // one clock behind the latch
        end
    end

    // readback, raster reads show the live counter rather than the compare
    always_comb
    begin
        case (bus.addr)
            REG_CONTROL1:   bus.rdata = {raster[`VIC_RASTER_W-1], 7'h00};
            REG_RASTER:     bus.rdata = raster[7:0];
            REG_VIDEO_BASE: bus.rdata = {video_base, 4'h0};
            REG_IRQ_STATUS: bus.rdata = {|pending, 3'b000, irq_status};
            REG_IRQ_ENABLE: bus.rdata = {4'h0, irq_en};
            REG_BORDER:     bus.rdata = {4'h0, border};
            default:        bus.rdata = 8'hFF;   // open slots
        endcase
    end

endmodule

// File: hw/vic_top.sv
// vic pin level top
`timescale 1ns/1ps
`include "vic_cfg.svh"

module vic_top (
    input  logic       clk_col16x_ntsc,
    input  logic       reset,
    input  logic       ce,          // active low chip enable
    input  logic       rw,          // high read, low write
    input  logic [5:0] adl_in,      // low address pins in
    input  logic [7:0] dbl_in,      // data pins in
    input  logic [3:0] dbh,         // unused color ram nibble
    output logic [5:0] adl_out,
    output logic [5:0] adl_oe,
    output logic [5:0] adh,
    output logic [7:0] dbl_out,
    output logic [7:0] dbl_oe,
    output logic       clk_phi,     // cpu clock
    output logic       aec,
    output logic       irq,         // active low open drain style
    output logic       cpu_reset
);
    import vic_pkg::*;

    logic [3:0]               phase;
    bus_phase_t               bus_phase;
    logic [7:0]               hcycle;
    logic [`VIC_RASTER_W-1:0] raster;
    logic [3:0]               video_base;
    logic [`VIC_ADDR_W-1:0]   fetch_addr;
    logic                     addr_drive;

    vic_bus_if reg_bus ();

    cycle_timer u_timer (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .reset           (reset),
        .phase           (phase),
        .bus_phase       (bus_phase),
        .clk_phi         (clk_phi),
        .cycle_end       (),
        .hcycle          (hcycle),
        .raster          (raster),
        .cpu_reset       (cpu_reset)
    );

    cpu_bus_port u_port (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .reset           (reset),
        .phase           (phase),
        .ce              (ce),
        .rw              (rw),
        .adl_in          (adl_in),
        .dbl_in          (dbl_in),
        .bus             (reg_bus.ctrl),
        .dbl_out         (dbl_out),
        .dbl_oe          (dbl_oe)
    );

    vic_regs u_regs (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .reset           (reset),
        .hcycle          (hcycle),
        .raster          (raster),
        .phase           (phase),
        .bus             (reg_bus.regs),
        .video_base      (video_base),
        .irq             (irq)
    );

    fetch_addr_gen u_fetch (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .reset           (reset),
        .bus_phase       (bus_phase),
        .hcycle          (hcycle),
        .video_base      (video_base),
        .fetch_addr      (fetch_addr),
        .addr_drive      (addr_drive)
    );

    // split the 12 bit fetch address onto the two pin groups
    assign adl_out = fetch_addr[5:0];
    assign adh     = fetch_addr[11:6];
    assign adl_oe  = {6{addr_drive}};  // low pins tristate in the cpu half
    assign aec     = ~clk_phi;         // vic holds the bus while phi is low

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module vic_tb -f compile.f -o vic_sim
out=$(./obj_dir/vic_sim)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"
